//--- verilog.f
hw/asram_pkg.sv
hw/wb_if.sv
hw/wb_decode.sv
hw/asram_ctrl.sv
hw/asram_regs.sv
hw/asram_subsys_top.sv
verif/sram_model.sv
verif/tb_asram_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the asram subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module tb_asram_subsys \
	-f verilog.f \
	-o tb_asram_subsys \
	&& ./obj_dir/tb_asram_subsys \
	|| exit 1

//--- verif/asram_testdata.hex
// asram subsystem transactions, one per line
// op (0 read, 1 write, f end)  address  lanes  write data  expected read data
// full words at both ends of the sram
1 00000 f 12345678 00000000
0 00000 f 00000000 12345678
1 00001 f deadbeef 00000000
1 3ffff f cafef00d 00000000
0 3ffff f 00000000 cafef00d
0 00001 f 00000000 deadbeef
// partial lanes, expected word is the merge
1 00010 f 11223344 00000000
1 00010 1 000000aa 00000000
1 00010 6 55667700 00000000
0 00010 f 00000000 116677aa
1 00011 f 11111111 00000000
1 00011 a bb99cc88 00000000
0 00011 f 00000000 bb11cc11
// register block, identity and scratch
0 40001 f 00000000 a5a00001
1 40000 f 87654321 00000000
0 40000 f 00000000 87654321
1 40000 c 9abcffff 00000000
0 40000 f 00000000 9abc4321
// counters after eight sram writes and five reads
0 40002 f 00000000 00000008
0 40003 f 00000000 00000005
// clear write count, then one more of each
1 40002 f 00000000 00000000
0 40002 f 00000000 00000000
1 00005 f 0badc0de 00000000
0 00005 f 00000000 0badc0de
0 40002 f 00000000 00000001
0 40003 f 00000000 00000006
// clear read count, one read in between
1 40003 f 00000000 00000000
0 40003 f 00000000 00000000
0 00000 f 00000000 12345678
0 40003 f 00000000 00000001
// end of run
f 00000 0 00000000 00000000

//--- verif/tb_asram_subsys.sv
// testbench for the asram subsystem, replays testdata records against an sram model
`timescale 1ns/1ps

module tb_asram_subsys;

	localparam int ACCESS_CYCLE = 2;
	// one record is op, address, lanes, write data and expected data
	localparam int REC_WORDS    = 5;
	localparam int MAX_RECORDS  = 64;
	localparam logic [31:0] OP_WRITE = 32'h1;
	localparam logic [31:0] OP_END   = 32'hF;

	logic                 clk;
	logic                 reset;
	asram_pkg::bus_adr_t  wb_adr;
	asram_pkg::wb_dat_t   wb_dat_w;
	logic                 wb_we;
	asram_pkg::wb_sel_t   wb_sel;
	logic                 wb_stb;
	asram_pkg::wb_dat_t   wb_dat_r;
	logic                 wb_ack;
	logic                 asram_cs_n;
	logic                 asram_we_n;
	logic                 asram_oe_n;
	asram_pkg::wb_sel_t   asram_bls_n;
	asram_pkg::sram_adr_t asram_a;
	wire [asram_pkg::DAT_W-1:0] asram_d;

	logic [31:0] vectors [0:MAX_RECORDS*REC_WORDS-1];
	int num_records;
	int cycle_count = 0;
	int cycle_limit = 100000;
	// sram accesses since the last counter clear
	int sram_writes = 0;
	int sram_reads  = 0;

	asram_subsys_top #(
		.ACCESS_CYCLE (ACCESS_CYCLE)
	) dut_i (
		.clk           (clk),
		.reset         (reset),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_we_i       (wb_we),
		.wb_sel_i      (wb_sel),
		.wb_stb_i      (wb_stb),
		.wb_dat_o      (wb_dat_r),
		.wb_ack_o      (wb_ack),
		.asram_cs_n_o  (asram_cs_n),
		.asram_we_n_o  (asram_we_n),
		.asram_oe_n_o  (asram_oe_n),
		.asram_bls_n_o (asram_bls_n),
		.asram_a_o     (asram_a),
		.asram_d       (asram_d)
	);

	sram_model u_sram (
		.cs_n_i  (asram_cs_n),
		.we_n_i  (asram_we_n),
		.oe_n_i  (asram_oe_n),
		.bls_n_i (asram_bls_n),
		.a_i     (asram_a),
		.dq      (asram_d)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// ------------------------------------------------------------
	// reporting
	// ------------------------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("** Error: %s expected 0x%08h, got 0x%08h",
				name, expected, actual));
		end
	endtask

	// run watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			fail_run($sformatf("timeout after %0d cycles, the test did not finish",
				cycle_count));
		end
	end

	// ------------------------------------------------------------
	// one single-beat transaction
	// ------------------------------------------------------------
	task automatic bus_access(input logic we, input asram_pkg::bus_adr_t adr,
			input asram_pkg::wb_sel_t sel, input asram_pkg::wb_dat_t wdata,
			output asram_pkg::wb_dat_t rdata, output int latency);
		int                 waited;
		// cycles seen with the chip selected
		int                 active;
		asram_pkg::wb_sel_t lanes_n;
		lanes_n = ~sel;
		active  = 0;
		@(posedge clk);
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		wb_we    <= we;
		wb_sel   <= sel;
		wb_stb   <= 1'b1;
		// latency counts from the edge that raised stb
		@(posedge clk);
		waited = 1;
		@(negedge clk);
		while (!wb_ack && waited < ACCESS_CYCLE + 3) begin
			// pins of a running sram access
			if (!asram_cs_n) begin
				active++;
				check_value("asram_a_o", 32'(asram_a),
					32'(adr[asram_pkg::SRAM_ADR_W-1:0]));
				check_value("asram_bls_n_o", 32'(asram_bls_n), 32'(lanes_n));
				check_value("asram_we_n_o", 32'(asram_we_n), we ? 32'h0 : 32'h1);
			end
			waited++;
			@(negedge clk);
		end
		if (!wb_ack) begin
			fail_run($sformatf("no ack within %0d cycles for address 0x%05h",
				ACCESS_CYCLE + 3, adr));
		end
		// chip selected for the access time, never for the registers
		check_value("asram_cs_n_o low cycles", 32'(active),
			adr[asram_pkg::BUS_ADR_W-1] ? 32'd0 : 32'(ACCESS_CYCLE));
		rdata   = wb_dat_r;
		latency = waited;
		// ack seen at this edge, stb low for one cycle
		@(posedge clk);
		wb_stb <= 1'b0;
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int                  base;
		logic                we;
		asram_pkg::bus_adr_t adr;
		asram_pkg::wb_sel_t  sel;
		asram_pkg::wb_dat_t  wdata;
		asram_pkg::wb_dat_t  expected;
		asram_pkg::wb_dat_t  rdata;
		int                  latency;
		logic                region;
		clk      = 1'b0;
		reset    = 1'b1;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_we    = 1'b0;
		wb_sel   = '0;
		wb_stb   = 1'b0;

		$readmemh("verif/asram_testdata.hex", vectors);
		num_records = 0;
		while (num_records < MAX_RECORDS && vectors[num_records*REC_WORDS] !== OP_END) begin
			num_records++;
		end
		if (num_records == MAX_RECORDS) begin
			fail_run("testdata has no end record");
		end
		cycle_limit = num_records * (ACCESS_CYCLE + 4) + 100;

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// idle pins before the first request
		check_value("asram_cs_n_o", 32'(asram_cs_n), 32'h1);
		check_value("asram_we_n_o", 32'(asram_we_n), 32'h1);
		check_value("asram_oe_n_o", 32'(asram_oe_n), 32'h1);
		check_value("asram_bls_n_o", 32'(asram_bls_n), 32'hF);
		check_value("wb_ack_o", 32'(wb_ack), 32'h0);

		for (int rec = 0; rec < num_records; rec++) begin
			base     = rec * REC_WORDS;
			we       = (vectors[base] == OP_WRITE);
			adr      = vectors[base + 1][asram_pkg::BUS_ADR_W-1:0];
			sel      = vectors[base + 2][asram_pkg::SEL_W-1:0];
			wdata    = vectors[base + 3];
			expected = vectors[base + 4];
			region   = adr[asram_pkg::BUS_ADR_W-1];
			if (vectors[base] > OP_WRITE) begin
				fail_run($sformatf("testdata record %0d has an unknown op", rec));
			end

			bus_access(we, adr, sel, wdata, rdata, latency);
			// sram takes the access time plus one, registers one
			check_value("ack latency", 32'(latency), region ? 32'd1 : 32'(ACCESS_CYCLE + 1));
			if (!we) begin
				check_value("wb_dat_o", rdata, expected);
				if (region && adr[1:0] == asram_pkg::REG_WR_COUNT) begin
					check_value("wr_count", rdata, 32'(sram_writes));
				end
				if (region && adr[1:0] == asram_pkg::REG_RD_COUNT) begin
					check_value("rd_count", rdata, 32'(sram_reads));
				end
			end

			// own access count, cleared like the counters
			if (!region) begin
				if (we) begin
					sram_writes++;
				end else begin
					sram_reads++;
				end
			end else if (we && adr[1:0] == asram_pkg::REG_WR_COUNT) begin
				sram_writes = 0;
			end else if (we && adr[1:0] == asram_pkg::REG_RD_COUNT) begin
				sram_reads = 0;
			end
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- verif/sram_model.sv
// behavioral asynchronous sram with byte lanes and a tristate data bus
`timescale 1ns/1ps

module sram_model #(
	parameter int ADR_W = 18,
	parameter int DAT_W = 32
) (
	input  logic               cs_n_i,
	input  logic               we_n_i,
	input  logic               oe_n_i,
	input  logic [DAT_W/8-1:0] bls_n_i,
	input  logic [ADR_W-1:0]   a_i,
	inout  wire  [DAT_W-1:0]   dq
);

	// full array, 2^ADR_W words
	logic [DAT_W-1:0] mem [0:(1<<ADR_W)-1];

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------

	// pins all change on one clock edge and then hold
	// for the whole access, so one write after they settle
	// gives the same result as a level-sensitive array
	always @(negedge we_n_i) begin
		#1;
		if (!cs_n_i && !we_n_i) begin
			for (int i = 0; i < DAT_W/8; i++) begin
				// only lanes with bls_n low
				if (!bls_n_i[i]) begin
					mem[a_i][8*i +: 8] = dq[8*i +: 8];
				end
			end
		end
	end

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------

	// drive only with chip and output enable both low
	assign dq = (!cs_n_i && !oe_n_i) ? mem[a_i] : 'z;

endmodule

//--- hw/asram_subsys_top.sv
// asram subsystem top, wishbone slave port with sram and register regions
`timescale 1ns/1ps

module asram_subsys_top #(
	parameter int ACCESS_CYCLE = 1
) (
	input  logic                 clk,
	input  logic                 reset,

	// ------------------------------------------------------------
	// wishbone slave port
	// ------------------------------------------------------------
	input  asram_pkg::bus_adr_t  wb_adr_i,
	input  asram_pkg::wb_dat_t   wb_dat_i,
	input  logic                 wb_we_i,
	input  asram_pkg::wb_sel_t   wb_sel_i,
	input  logic                 wb_stb_i,
	output asram_pkg::wb_dat_t   wb_dat_o,
	output logic                 wb_ack_o,

	// ------------------------------------------------------------
	// external sram
	// ------------------------------------------------------------
	output logic                 asram_cs_n_o,
	output logic                 asram_we_n_o,
	output logic                 asram_oe_n_o,
	output asram_pkg::wb_sel_t   asram_bls_n_o,
	output asram_pkg::sram_adr_t asram_a_o,
	inout  wire asram_pkg::wb_dat_t asram_d
);

	// region links
	wb_if sram_bus ();
	wb_if reg_bus ();

	// access done pulses, controller to counters
	logic sram_wr_done;
	logic sram_rd_done;

	wb_decode u_decode (
		.clk      (clk),
		.reset    (reset),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_sel_i (wb_sel_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.sram_bus (sram_bus),
		.reg_bus  (reg_bus)
	);

	asram_ctrl #(
		.ACCESS_CYCLE (ACCESS_CYCLE)
	) u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.bus            (sram_bus),
		.asram_cs_n_o   (asram_cs_n_o),
		.asram_we_n_o   (asram_we_n_o),
		.asram_oe_n_o   (asram_oe_n_o),
		.asram_bls_n_o  (asram_bls_n_o),
		.asram_a_o      (asram_a_o),
		.asram_d        (asram_d),
		.sram_wr_done_o (sram_wr_done),
		.sram_rd_done_o (sram_rd_done)
	);

	asram_regs u_regs (
		.clk            (clk),
		.reset          (reset),
		.bus            (reg_bus),
		.sram_wr_done_i (sram_wr_done),
		.sram_rd_done_i (sram_rd_done)
	);

endmodule

//--- hw/asram_regs.sv
// register block with scratch, identity and sram access counters
`timescale 1ns/1ps

module asram_regs (
	input  logic clk,
	input  logic reset,

	// request from the decoder
	wb_if.slave  bus,

	// one pulse per finished sram access
	input  logic sram_wr_done_i,
	input  logic sram_rd_done_i
);

	// word offset inside the block
	logic [1:0]         ofs;
	// request accepted this cycle
	logic               req;
	logic               ack;

	asram_pkg::wb_dat_t scratch;
	asram_pkg::wb_dat_t wr_count;
	asram_pkg::wb_dat_t rd_count;
	asram_pkg::wb_dat_t rdata;

	assign ofs = bus.adr[1:0];
	// not in the ack cycle, which still shows the old request
	assign req = bus.stb & ~ack;

	// ------------------------------------------------------------
	// control and registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack      <= 1'b0;
			scratch  <= '0;
			wr_count <= '0;
			rd_count <= '0;
		end else begin
			// one cycle after stb
			ack <= req;

			// scratch by byte lane
			if (req && bus.we && ofs == asram_pkg::REG_SCRATCH) begin
				for (int i = 0; i < asram_pkg::SEL_W; i++) begin
					if (bus.sel[i]) begin
						scratch[8*i +: 8] <= bus.dat_w[8*i +: 8];
					end
				end
			end

			// counters wrap, any write clears
			if (req && bus.we && ofs == asram_pkg::REG_WR_COUNT) begin
				wr_count <= '0;
			end else if (sram_wr_done_i) begin
				wr_count <= wr_count + 1'b1;
			end

			if (req && bus.we && ofs == asram_pkg::REG_RD_COUNT) begin
				rd_count <= '0;
			end else if (sram_rd_done_i) begin
				rd_count <= rd_count + 1'b1;
			end
		end
	end

	// read mux, registered so data comes with ack
	always_ff @(posedge clk) begin
		if (req && !bus.we) begin
			case (ofs)
				asram_pkg::REG_SCRATCH:  rdata <= scratch;
				asram_pkg::REG_ID:       rdata <= asram_pkg::ASRAM_ID;
				asram_pkg::REG_WR_COUNT: rdata <= wr_count;
				default:                 rdata <= rd_count;
			endcase
		end
	end

	assign bus.ack   = ack;
	assign bus.dat_r = rdata;

endmodule

//--- hw/asram_ctrl.sv
// asynchronous sram controller, fixed access time with registered pins
`timescale 1ns/1ps

module asram_ctrl #(
	parameter int ACCESS_CYCLE = 1
) (
	input  logic                 clk,
	input  logic                 reset,

	// request from the decoder
	wb_if.slave                  bus,

	// sram pins
	output logic                 asram_cs_n_o,
	output logic                 asram_we_n_o,
	output logic                 asram_oe_n_o,
	output asram_pkg::wb_sel_t   asram_bls_n_o,
	output asram_pkg::sram_adr_t asram_a_o,
	inout  wire asram_pkg::wb_dat_t asram_d,

	// access done pulses for the counters
	output logic                 sram_wr_done_o,
	output logic                 sram_rd_done_o
);

	// wide enough for ACCESS_CYCLE-1
	localparam int CNT_W = $clog2(ACCESS_CYCLE + 1);

	asram_pkg::asram_state_e state;
	// cycles left with the pins active
	logic [CNT_W-1:0]        cnt;
	// direction of the running access
	logic                    op_we;
	asram_pkg::wb_dat_t      wdata;
	asram_pkg::wb_dat_t      rdata;

	logic                    acc_start;
	logic                    acc_last;

	// request seen while idle
	assign acc_start = (state == asram_pkg::ST_IDLE) && bus.stb;
	// final active cycle, pins drop at the next edge
	assign acc_last  = (state == asram_pkg::ST_ACCESS) && (cnt == '0);

	// ------------------------------------------------------------
	// sequencer and pin control
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state         <= asram_pkg::ST_IDLE;
			cnt           <= '0;
			op_we         <= 1'b0;
			asram_cs_n_o  <= 1'b1;
			asram_we_n_o  <= 1'b1;
			asram_oe_n_o  <= 1'b1;
			asram_bls_n_o <= '1;
			asram_a_o     <= '0;
		end else begin
			case (state)
				asram_pkg::ST_IDLE: begin
					if (acc_start) begin
						state         <= asram_pkg::ST_ACCESS;
						cnt           <= CNT_W'(ACCESS_CYCLE - 1);
						op_we         <= bus.we;
						// select the chip, then we_n for a write or oe_n for a read
						asram_cs_n_o  <= 1'b0;
						asram_we_n_o  <= ~bus.we;
						asram_oe_n_o  <= bus.we;
						asram_bls_n_o <= ~bus.sel;
						asram_a_o     <= bus.adr;
					end
				end
				asram_pkg::ST_ACCESS: begin
					if (acc_last) begin
						state         <= asram_pkg::ST_END;
						asram_cs_n_o  <= 1'b1;
						asram_we_n_o  <= 1'b1;
						asram_oe_n_o  <= 1'b1;
						asram_bls_n_o <= '1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				// ack cycle, back to idle
				asram_pkg::ST_END: begin
					state <= asram_pkg::ST_IDLE;
				end
				default: begin
					state <= asram_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// data path
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		// write data held for the whole access
		if (acc_start) begin
			wdata <= bus.dat_w;
		end
		// read data sampled as oe_n goes high
		if (acc_last) begin
			rdata <= asram_d;
		end
	end

	// drive the bus only while a write is active
	assign asram_d = asram_we_n_o ? 'z : wdata;

	// response
	assign bus.ack   = (state == asram_pkg::ST_END);
	assign bus.dat_r = rdata;

	// counter pulses line up with ack
	assign sram_wr_done_o = bus.ack & op_we;
	assign sram_rd_done_o = bus.ack & ~op_we;

	// sram output and our write driver must never fight
	a_no_contention: assert property (@(posedge clk) disable iff (reset)
		!(!asram_we_n_o && !asram_oe_n_o));

	// ack is a single pulse
	a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		bus.ack |=> !bus.ack);

endmodule

//--- hw/wb_decode.sv
// region decoder, steers requests to sram or registers and merges the responses
`timescale 1ns/1ps

module wb_decode (
	input  logic                 clk,
	input  logic                 reset,

	// top-level bus
	input  asram_pkg::bus_adr_t  wb_adr_i,
	input  asram_pkg::wb_dat_t   wb_dat_i,
	input  logic                 wb_we_i,
	input  asram_pkg::wb_sel_t   wb_sel_i,
	input  logic                 wb_stb_i,
	output asram_pkg::wb_dat_t   wb_dat_o,
	output logic                 wb_ack_o,

	// regions
	wb_if.master                 sram_bus,
	wb_if.master                 reg_bus
);

	// high selects the register block
	logic region;

	assign region = wb_adr_i[asram_pkg::BUS_ADR_W-1];

	// ------------------------------------------------------------
	// request fan-out
	// ------------------------------------------------------------

	// payload goes to both, only stb is steered
	assign sram_bus.adr   = wb_adr_i[asram_pkg::SRAM_ADR_W-1:0];
	assign sram_bus.dat_w = wb_dat_i;
	assign sram_bus.we    = wb_we_i;
	assign sram_bus.sel   = wb_sel_i;
	assign sram_bus.stb   = wb_stb_i & ~region;

	assign reg_bus.adr    = wb_adr_i[asram_pkg::SRAM_ADR_W-1:0];
	assign reg_bus.dat_w  = wb_dat_i;
	assign reg_bus.we     = wb_we_i;
	assign reg_bus.sel    = wb_sel_i;
	assign reg_bus.stb    = wb_stb_i & region;

	// ------------------------------------------------------------
	// response merge, no added latency
	// ------------------------------------------------------------
	assign wb_dat_o = region ? reg_bus.dat_r : sram_bus.dat_r;
	assign wb_ack_o = region ? reg_bus.ack   : sram_bus.ack;

	// only one region may ever answer
	a_one_ack: assert property (@(posedge clk) disable iff (reset)
		!(sram_bus.ack && reg_bus.ack));

	// master must hold the request until it sees ack
	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		(wb_stb_i && !wb_ack_o) |=> (wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i)
			&& $stable(wb_sel_i) && $stable(wb_dat_i)));

endmodule

//--- hw/wb_if.sv
// internal single-beat wishbone link between the decoder and one region
`timescale 1ns/1ps

interface wb_if;

	// request side, driven by the decoder
	asram_pkg::sram_adr_t adr;
	asram_pkg::wb_dat_t   dat_w;
	logic                 we;
	asram_pkg::wb_sel_t   sel;
	logic                 stb;

	// response side, driven by the region
	asram_pkg::wb_dat_t   dat_r;
	// single cycle, read data valid with it
	logic                 ack;

	modport master (
		output adr, dat_w, we, sel, stb,
		input  dat_r, ack
	);

	modport slave (
		input  adr, dat_w, we, sel, stb,
		output dat_r, ack
	);

endinterface

//--- hw/asram_pkg.sv
// asram subsystem shared widths, register map and controller state encoding
package asram_pkg;

	// ------------------------------------------------------------
	// bus and sram widths
	// ------------------------------------------------------------

	// word address on the top-level bus, msb picks the region
	localparam int BUS_ADR_W  = 19;
	// word address on the sram pins
	localparam int SRAM_ADR_W = 18;
	localparam int DAT_W      = 32;
	// one lane per byte
	localparam int SEL_W      = DAT_W / 8;

	typedef logic [BUS_ADR_W-1:0]  bus_adr_t;
	typedef logic [SRAM_ADR_W-1:0] sram_adr_t;
	typedef logic [DAT_W-1:0]      wb_dat_t;
	typedef logic [SEL_W-1:0]      wb_sel_t;

	// ------------------------------------------------------------
	// register block map, word offsets from the low address bits
	// ------------------------------------------------------------
	localparam logic [1:0] REG_SCRATCH  = 2'd0;
	localparam logic [1:0] REG_ID       = 2'd1;
	localparam logic [1:0] REG_WR_COUNT = 2'd2;
	localparam logic [1:0] REG_RD_COUNT = 2'd3;

	// identity word, read only
	localparam wb_dat_t ASRAM_ID = 32'hA5A0_0001;

	// sram access sequencer
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_END
	} asram_state_e;

endpackage
